/* spi_ctrl.f */
source/spi_types_pkg.sv
source/spi_cfg_pkg.sv
source/sync_fifo.sv
source/spi_master.sv
source/spi_controller.sv
source/spi_subsystem.sv
verification/spi_slave_model.sv
verification/tb_spi_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_spi_subsystem
FILELIST  ?= spi_ctrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator status is ignored here, the log decides
run: compile
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/tb_spi_subsystem.sv */
`timescale 1ns/1ps

module tb_spi_subsystem;

    import spi_types_pkg::*;
    import spi_cfg_pkg::*;

    localparam int clk_div = DEFAULT_CLK_DIV;
    localparam int fifo_depth = 1 << DEFAULT_FIFO_ADDR_W;
    // clk cycles for one byte on the wire
    localparam int byte_cycles = 16 * clk_div;
    localparam int num_tests = 5;
    // 40 byte times per test plus margin
    // 100 ns per clk cycle
    localparam int watchdog_ns = (num_tests * 40 * byte_cycles + 1000) * 100;
    // slave answer right after reset
    localparam logic [SPI_DATA_W-1:0] first_answer = 8'hA5;

    logic clk;
    logic rst;
    logic wr;
    logic [SPI_DATA_W-1:0] din;
    logic ignore_response;
    logic rd;
    logic miso;
    logic [SPI_DATA_W-1:0] dout;
    logic data_avail;
    logic buffer_empty;
    logic buffer_full;
    logic cs;
    logic sck;
    logic mosi;

    // slave observation
    logic [SPI_DATA_W-1:0] slave_last;
    int slave_count;
    int slave_cs_falls;

    // bytes sent this test, their flags, and the answers still owed
    logic [SPI_DATA_W-1:0] sent_q[$];
    logic ign_q[$];
    logic [SPI_DATA_W-1:0] exp_q[$];
    integer seed = 87;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    spi_subsystem #(
        .clk_div(clk_div),
        .fifo_addr_w(DEFAULT_FIFO_ADDR_W)
    ) u_spi_subsystem (
        .clk(clk),
        .rst(rst),
        .wr(wr),
        .din(din),
        .ignore_response(ignore_response),
        .rd(rd),
        .miso(miso),
        .dout(dout),
        .data_avail(data_avail),
        .buffer_empty(buffer_empty),
        .buffer_full(buffer_full),
        .cs(cs),
        .sck(sck),
        .mosi(mosi)
    );

    spi_slave_model u_slave (
        .rst(rst),
        .cs(cs),
        .sck(sck),
        .mosi(mosi),
        .miso(miso),
        .last_rx(slave_last),
        .rx_count(slave_count),
        .cs_falls(slave_cs_falls)
    );

    ////////////////////////////////
    // compare and stop
    ////////////////////////////////

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [SPI_DATA_W-1:0] exp,
                              input logic [SPI_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            stop_run("byte compare failed");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s expected %b actual %b", name, exp, act);
            stop_run("flag compare failed");
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Mismatch %s expected %0d actual %0d", name, exp, act);
            stop_run("count compare failed");
        end
    endtask

    ////////////////////////////////
    // host bus helpers
    ////////////////////////////////

    // inputs change 1 ns past the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic reset_dut();
        step();
        wr = 1'b0;
        din = '0;
        ignore_response = 1'b0;
        rd = 1'b0;
        rst = 1'b1;
        repeat (5) step();
        rst = 1'b0;
        sent_q.delete();
        ign_q.delete();
        exp_q.delete();
        step();
    endtask

    // one cycle of wr per call
    // calls in a row give back to back writes
    task automatic write_byte(input logic [SPI_DATA_W-1:0] data, input logic ign);
        if (buffer_full) stop_run("host write attempted while buffer_full was set");
        wr = 1'b1;
        din = data;
        ignore_response = ign;
        sent_q.push_back(data);
        ign_q.push_back(ign);
        step();
        wr = 1'b0;
        din = '0;
        ignore_response = 1'b0;
    endtask

    function automatic logic [SPI_DATA_W-1:0] random_byte();
        int rnd;
        rnd = $random(seed);
        return rnd[SPI_DATA_W-1:0];
    endfunction

    // slave echoes the byte before
    // dropped answers never get queued
    function automatic void build_expected();
        logic [SPI_DATA_W-1:0] prev;
        prev = first_answer;
        exp_q.delete();
        foreach (sent_q[i]) begin
            if (!ign_q[i]) exp_q.push_back(prev);
            prev = sent_q[i];
        end
    endfunction

    task automatic wait_idle(input string name);
        int waited;
        int limit;
        waited = 0;
        limit = (sent_q.size() + 1) * (byte_cycles + 2 * clk_div);
        while (!(cs && buffer_empty)) begin
            if (waited > limit) stop_run({name, ": transfers did not finish in time"});
            step();
            waited++;
        end
    endtask

    task automatic wait_slave_count(input string name, input int n);
        int waited;
        waited = 0;
        while (slave_count < n) begin
            if (waited > (n + 1) * (byte_cycles + 2 * clk_div))
                stop_run({name, ": slave did not receive enough bytes in time"});
            step();
            waited++;
        end
    endtask

    // pop every owed answer in order once data_avail is up
    task automatic read_expected(input string name);
        int waited;
        logic [SPI_DATA_W-1:0] exp;
        while (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            waited = 0;
            while (!data_avail) begin
                if (waited > 3 * byte_cycles) stop_run({name, ": response byte never arrived"});
                step();
                waited++;
            end
            check_byte({name, " dout"}, exp, dout);
            rd = 1'b1;
            step();
            rd = 1'b0;
        end
        check_flag({name, " data_avail after reads"}, 1'b0, data_avail);
    endtask

    ////////////////////////////////
    // directed tests
    ////////////////////////////////

    task automatic test_reset_state();
        reset_dut();
        check_flag("reset buffer_empty", 1'b1, buffer_empty);
        check_flag("reset buffer_full", 1'b0, buffer_full);
        check_flag("reset data_avail", 1'b0, data_avail);
        check_flag("reset cs", 1'b1, cs);
        check_flag("reset sck", 1'b0, sck);
        check_flag("reset mosi", 1'b0, mosi);
        check_byte("reset dout", '0, dout);
    endtask

    task automatic test_single_byte();
        reset_dut();
        write_byte(8'h3C, 1'b0);
        build_expected();
        read_expected("single");
        check_byte("single slave byte", 8'h3C, slave_last);
        check_count("single cs falls", 1, slave_cs_falls);
    endtask

    task automatic test_burst();
        reset_dut();
        repeat (6) write_byte(random_byte(), 1'b0);
        wait_idle("burst");
        // cs held low across the whole burst
        check_count("burst cs falls", 1, slave_cs_falls);
        check_count("burst slave bytes", 6, slave_count);
        check_byte("burst slave last", sent_q[5], slave_last);
        build_expected();
        read_expected("burst");
    endtask

    task automatic test_ignore();
        reset_dut();
        write_byte(8'h11, 1'b0);
        write_byte(8'h22, 1'b1);
        write_byte(8'h33, 1'b1);
        write_byte(8'h44, 1'b0);
        wait_idle("ignore");
        check_count("ignore slave bytes", 4, slave_count);
        build_expected();
        read_expected("ignore");
    endtask

    task automatic test_back_pressure();
        reset_dut();
        // first byte goes straight to the engine
        // the other sixteen fill the queue
        repeat (fifo_depth + 1) write_byte(random_byte(), 1'b0);
        check_flag("pressure buffer_full", 1'b1, buffer_full);
        wait_slave_count("pressure", fifo_depth);
        // with the receive queue full the last byte stays queued
        repeat (2 * byte_cycles) step();
        check_count("pressure stalled bytes", fifo_depth, slave_count);
        check_flag("pressure cs held", 1'b0, cs);
        check_flag("pressure buffer_empty", 1'b0, buffer_empty);
        check_flag("pressure data_avail", 1'b1, data_avail);
        build_expected();
        read_expected("pressure");
        check_count("pressure slave bytes", fifo_depth + 1, slave_count);
        check_count("pressure cs falls", 1, slave_cs_falls);
    endtask

    ////////////////////////////////
    // sequence and watchdog
    ////////////////////////////////

    initial begin
        rst = 1'b0;
        wr = 1'b0;
        din = '0;
        ignore_response = 1'b0;
        rd = 1'b0;
        test_reset_state();
        test_single_byte();
        test_burst();
        test_ignore();
        test_back_pressure();
        $display("TEST OK");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        stop_run("watchdog expired before the tests completed");
    end

endmodule

/* verification/spi_slave_model.sv */
`timescale 1ns/1ps

module spi_slave_model (
    input  logic                                 rst,
    input  logic                                 cs,
    input  logic                                 sck,
    input  logic                                 mosi,
    output logic                                 miso,
    output logic [spi_types_pkg::SPI_DATA_W-1:0] last_rx,
    output int                                   rx_count,
    output int                                   cs_falls
);

    import spi_types_pkg::*;

    logic [SPI_DATA_W-1:0] rx_shift;
    logic [SPI_DATA_W-1:0] tx_shift;
    // bits taken in for the current byte
    int bit_cnt;

    ////////////////////////////////
    // receive side
    ////////////////////////////////

    // mode 0, mosi sampled on rising sck, msb first
    always @(posedge sck or posedge rst) begin
        if (rst) begin
            rx_shift <= '0;
            bit_cnt  <= 0;
            last_rx  <= 8'hA5;
            rx_count <= 0;
        end else if (!cs) begin
            rx_shift <= {rx_shift[SPI_DATA_W-2:0], mosi};
            if (bit_cnt == SPI_DATA_W - 1) begin
                // byte complete, it becomes the next answer
                bit_cnt  <= 0;
                last_rx  <= {rx_shift[SPI_DATA_W-2:0], mosi};
                rx_count <= rx_count + 1;
            end else begin
                bit_cnt <= bit_cnt + 1;
            end
        end
    end

    ////////////////////////////////
    // answer side
    ////////////////////////////////

    // miso moves on falling sck
    // bit_cnt of zero means cs just fell or a byte just ended
    always @(negedge sck or negedge cs or posedge rst) begin
        if (rst) begin
            tx_shift <= '0;
            miso     <= 1'b0;
        end else if (!cs) begin
            if (bit_cnt == 0) begin
                tx_shift <= last_rx;
                miso     <= last_rx[SPI_DATA_W-1];
            end else begin
                tx_shift <= {tx_shift[SPI_DATA_W-2:0], 1'b0};
                miso     <= tx_shift[SPI_DATA_W-2];
            end
        end
    end

    // one count per transaction frame
    always @(negedge cs or posedge rst) begin
        if (rst) begin
            cs_falls <= 0;
        end else begin
            cs_falls <= cs_falls + 1;
        end
    end

endmodule

/* source/spi_subsystem.sv */
`timescale 1ns/1ps

module spi_subsystem #(
    parameter int clk_div     = spi_cfg_pkg::DEFAULT_CLK_DIV,
    parameter int fifo_addr_w = spi_cfg_pkg::DEFAULT_FIFO_ADDR_W
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 wr,
    input  logic [spi_types_pkg::SPI_DATA_W-1:0] din,
    input  logic                                 ignore_response,
    input  logic                                 rd,
    input  logic                                 miso,
    output logic [spi_types_pkg::SPI_DATA_W-1:0] dout,
    output logic                                 data_avail,
    output logic                                 buffer_empty,
    output logic                                 buffer_full,
    output logic                                 cs,
    output logic                                 sck,
    output logic                                 mosi
);

    // host strobes in, spi pins out
    spi_controller #(
        .clk_div(clk_div),
        .fifo_addr_w(fifo_addr_w)
    ) u_spi_controller (
        .clk(clk),
        .rst(rst),
        .wr(wr),
        .din(din),
        .ignore_response(ignore_response),
        .rd(rd),
        .miso(miso),
        .dout(dout),
        .data_avail(data_avail),
        .buffer_empty(buffer_empty),
        .buffer_full(buffer_full),
        .cs(cs),
        .sck(sck),
        .mosi(mosi)
    );

endmodule

/* source/spi_controller.sv */
`timescale 1ns/1ps

module spi_controller #(
    parameter int clk_div     = spi_cfg_pkg::DEFAULT_CLK_DIV,
    parameter int fifo_addr_w = spi_cfg_pkg::DEFAULT_FIFO_ADDR_W
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 wr,
    input  logic [spi_types_pkg::SPI_DATA_W-1:0] din,
    input  logic                                 ignore_response,
    input  logic                                 rd,
    input  logic                                 miso,
    output logic [spi_types_pkg::SPI_DATA_W-1:0] dout,
    output logic                                 data_avail,
    output logic                                 buffer_empty,
    output logic                                 buffer_full,
    output logic                                 cs,
    output logic                                 sck,
    output logic                                 mosi
);

    import spi_types_pkg::*;

    localparam logic seq_idle   = 1'b0;
    localparam logic seq_active = 1'b1;

    // transmit queue
    logic tx_push;
    logic tx_pop;
    logic [TX_ENTRY_W-1:0] tx_push_data;
    logic [TX_ENTRY_W-1:0] tx_head;
    logic tx_empty;
    logic tx_full;

    // receive queue
    logic rx_push;
    logic rx_pop;
    logic [SPI_DATA_W-1:0] rx_head;
    logic rx_empty;
    logic rx_full;

    // engine handshake
    logic start;
    logic hold;
    logic done;
    logic busy;
    logic [SPI_DATA_W-1:0] tx_byte;
    logic [SPI_DATA_W-1:0] rx_byte;

    logic seq_state;
    // flag of the byte in flight
    logic cur_ignore;
    logic launch_ok;
    logic launch;

    ////////////////////////////////
    // host side
    ////////////////////////////////

    assign tx_push      = wr && !tx_full;
    assign tx_push_data = {ignore_response, din};
    assign rx_pop       = rd && !rx_empty;
    assign buffer_empty = tx_empty;
    assign buffer_full  = tx_full;
    assign data_avail   = !rx_empty;
    // zero when nothing is queued
    assign dout = rx_empty ? '0 : rx_head;

    ////////////////////////////////
    // sequencer
    ////////////////////////////////

    // head may go if engine is free and its answer has a slot
    assign launch_ok = !tx_empty && !busy && (tx_head[IGNORE_BIT] || !rx_full);

    // from idle, or chained on done when rx_full is already settled
    assign launch = (seq_state == seq_idle) ? launch_ok :
                    (done && launch_ok && (cur_ignore || tx_head[IGNORE_BIT]));

    assign tx_pop  = launch;
    assign rx_push = done && !cur_ignore;
    // keep cs low while more bytes wait
    assign hold = !tx_empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seq_state  <= seq_idle;
            start      <= 1'b0;
            cur_ignore <= 1'b0;
        end else begin
            start <= launch;
            if (launch) begin
                cur_ignore <= tx_head[IGNORE_BIT];
            end
            case (seq_state)
                seq_idle: if (launch) seq_state <= seq_active;
                // back to idle to recheck rx space after a push
                seq_active: if (done && !launch) seq_state <= seq_idle;
                default: seq_state <= seq_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            tx_byte <= tx_head[SPI_DATA_W-1:0];
        end
    end

    sync_fifo #(.width(TX_ENTRY_W), .addr_w(fifo_addr_w)) tx_fifo (
        .clk(clk), .rst(rst), .push(tx_push), .push_data(tx_push_data),
        .pop(tx_pop), .head(tx_head), .empty(tx_empty), .full(tx_full)
    );

    sync_fifo #(.width(SPI_DATA_W), .addr_w(fifo_addr_w)) rx_fifo (
        .clk(clk), .rst(rst), .push(rx_push), .push_data(rx_byte),
        .pop(rx_pop), .head(rx_head), .empty(rx_empty), .full(rx_full)
    );

    spi_master #(.clk_div(clk_div)) u_spi_master (
        .clk(clk), .rst(rst), .start(start), .hold(hold), .tx_byte(tx_byte),
        .miso(miso), .rx_byte(rx_byte), .done(done), .busy(busy),
        .cs(cs), .sck(sck), .mosi(mosi)
    );

    // host has to watch buffer_full
    a_no_wr_full: assert property (@(posedge clk) disable iff (rst) wr |-> !buffer_full)
        else $error("spi_controller: write while transmit queue full");

endmodule

/* source/spi_master.sv */
`timescale 1ns/1ps

module spi_master #(
    parameter int clk_div = spi_cfg_pkg::DEFAULT_CLK_DIV
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               start,
    input  logic                               hold,
    input  logic [spi_types_pkg::SPI_DATA_W-1:0] tx_byte,
    input  logic                               miso,
    output logic [spi_types_pkg::SPI_DATA_W-1:0] rx_byte,
    output logic                               done,
    output logic                               busy,
    output logic                               cs,
    output logic                               sck,
    output logic                               mosi
);

    import spi_types_pkg::*;

    // divider counter width, at least one bit
    localparam int cnt_w = (clk_div > 1) ? $clog2(clk_div) : 1;
    // two sck half periods per bit
    localparam int last_half = 2 * SPI_DATA_W - 1;
    localparam int half_w = $clog2(2 * SPI_DATA_W);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_shift = 2'd1;
    localparam logic [1:0] st_tail  = 2'd2;

    logic [1:0] state;
    logic [cnt_w-1:0] div_cnt;
    logic [half_w-1:0] half_cnt;
    logic [SPI_DATA_W-1:0] tx_shift;

    logic div_wrap;
    logic rise_now;
    logic fall_now;

    // end of a half period
    assign div_wrap = (div_cnt == cnt_w'(clk_div - 1));
    // sck about to go high, sample miso
    assign rise_now = (state == st_shift) && div_wrap && !sck;
    // sck about to go low, next mosi bit
    assign fall_now = (state == st_shift) && div_wrap && sck;

    // tail counts down to the cs release too
    assign busy = (state != st_idle);

    ////////////////////////////////
    // control and pins
    ////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            div_cnt  <= '0;
            half_cnt <= '0;
            done     <= 1'b0;
            cs       <= 1'b1;
            sck      <= 1'b0;
            mosi     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    // cs may already be low from a held burst
                    if (start) begin
                        state    <= st_shift;
                        div_cnt  <= '0;
                        half_cnt <= '0;
                        cs       <= 1'b0;
                        mosi     <= tx_byte[SPI_DATA_W-1];
                    end
                end
                st_shift: begin
                    if (div_wrap) begin
                        div_cnt  <= '0;
                        sck      <= ~sck;
                        half_cnt <= half_cnt + 1'b1;
                        if (sck && half_cnt == half_w'(last_half)) begin
                            // last falling edge, byte complete
                            done  <= 1'b1;
                            state <= hold ? st_idle : st_tail;
                        end else if (sck) begin
                            mosi <= tx_shift[SPI_DATA_W-2];
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                st_tail: begin
                    // cs high clk_div cycles after done
                    if (div_wrap) begin
                        cs    <= 1'b1;
                        state <= st_idle;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    ////////////////////////////////
    // shift registers
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            tx_shift <= tx_byte;
        end else if (fall_now) begin
            tx_shift <= {tx_shift[SPI_DATA_W-2:0], 1'b0};
        end
        // msb first in, complete before done
        if (rise_now) begin
            rx_byte <= {rx_byte[SPI_DATA_W-2:0], miso};
        end
    end

    // sequencer must wait out the tail and the shift
    a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else $error("spi_master: start while busy");

endmodule

/* source/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int width  = 8,
    parameter int addr_w = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [width-1:0] push_data,
    input  logic             pop,
    output logic [width-1:0] head,
    output logic             empty,
    output logic             full
);

    localparam int depth = 1 << addr_w;

    // storage array
    logic [width-1:0] mem [depth];

    // pointers carry one extra wrap bit
    logic [addr_w:0] wr_ptr;
    logic [addr_w:0] rd_ptr;

    logic do_push;
    logic do_pop;

    ////////////////////////////////
    // flags and head
    ////////////////////////////////

    // same address, same lap
    assign empty = (wr_ptr == rd_ptr);

    // same address, writer one lap ahead
    assign full = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                  (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

    // fall-through read, head valid while not empty
    assign head = mem[rd_ptr[addr_w-1:0]];

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    ////////////////////////////////
    // storage and pointers
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[addr_w-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // new head shows up the cycle after the pop edge
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // the owner must watch full and empty before it strobes
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("sync_fifo: push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("sync_fifo: pop while empty");

endmodule

/* source/spi_cfg_pkg.sv */
package spi_cfg_pkg;

    // clk cycles per sck half period
    // 4 gives sck at clk / 8
    localparam int DEFAULT_CLK_DIV = 4;

    // log2 of queue depth, 16 entries
    localparam int DEFAULT_FIFO_ADDR_W = 4;

endpackage

/* source/spi_types_pkg.sv */
package spi_types_pkg;

    ////////////////////////////////
    // spi byte and queue entries
    ////////////////////////////////

    // one byte on the wire
    localparam int SPI_DATA_W = 8;

    // transmit entry holds the ignore flag above the data byte
    localparam int TX_ENTRY_W = SPI_DATA_W + 1;

    // flag position inside a transmit entry
    // set means the byte clocked back in is dropped
    localparam int IGNORE_BIT = SPI_DATA_W;

endpackage
